/* ssc_pkg.sv */
/*
 * snack shopping calculator constants
 * widths, counts and card check values shared by every pipeline stage
 */
`default_nettype none

package ssc_pkg;

    // ========================================
    // card number
    // ========================================
    localparam int DIGIT_W     = 4;     // one bcd digit, also one slot field
    localparam int CARD_DIGITS = 16;
    localparam int CARD_W      = 64;    // CARD_DIGITS * DIGIT_W
    localparam int LUHN_SUB    = 9;     // taken off a doubled digit >= 10
    localparam int LUHN_MOD    = 10;    // good card when sum % 10 == 0

    // ========================================
    // snacks and money
    // ========================================
    localparam int SNACKS      = 8;
    localparam int SLOT_W      = 32;    // eight packed nibbles
    localparam int COST_W      = 8;     // 4b qty * 4b price
    localparam int MONEY_W     = 9;

    // pipeline depth, cost -> sort -> change
    localparam int STAGES      = 3;

endpackage

`default_nettype wire

/* ssc_stage_if.sv */
/*
 * pipeline stage link
 * one transaction between two stages with a valid/ready handshake,
 * money paid, card check result and the eight slot costs
 */
`timescale 1ns/1ps
`default_nettype none

interface ssc_stage_if;

    logic                        valid;
    logic                        ready;
    logic [ssc_pkg::MONEY_W-1:0] money;
    logic                        card_ok;
    logic [ssc_pkg::COST_W-1:0]  cost [ssc_pkg::SNACKS];   // slot 0 first

    // upstream stage, owns the payload
    modport src (
        output valid, money, card_ok, cost,
        input  ready
    );

    // downstream stage, owns ready
    modport dst (
        input  valid, money, card_ok, cost,
        output ready
    );

endinterface

`default_nettype wire

/* card_check.sv */
/*
 * luhn card check
 * doubles every other digit from the msd side, folds by 9,
 * sums all sixteen digits in a balanced tree and tests for a multiple of 10
 */
`timescale 1ns/1ps
`default_nettype none

module card_check (
    input  wire logic [ssc_pkg::CARD_W-1:0] card_num,
    output logic                            card_ok
);

    // 16 terms of up to 5 bits need 9 bits of sum
    logic [ssc_pkg::DIGIT_W+4:0] term [ssc_pkg::CARD_DIGITS];
    logic [ssc_pkg::DIGIT_W+4:0] lvl1 [ssc_pkg::CARD_DIGITS/2];
    logic [ssc_pkg::DIGIT_W+4:0] lvl2 [ssc_pkg::CARD_DIGITS/4];
    logic [ssc_pkg::DIGIT_W+4:0] lvl3 [ssc_pkg::CARD_DIGITS/8];
    logic [ssc_pkg::DIGIT_W+4:0] sum;

    always_comb begin
        logic [ssc_pkg::DIGIT_W-1:0] dig;
        for (int i = 0; i < ssc_pkg::CARD_DIGITS; i++) begin
            dig = card_num[(ssc_pkg::CARD_DIGITS-1-i)*ssc_pkg::DIGIT_W +: ssc_pkg::DIGIT_W];
            term[i] = (ssc_pkg::DIGIT_W+5)'(dig);
            if (i % 2 == 0) begin
                term[i] = term[i] << 1;     // even position from msd, doubled
                if (term[i] >= (ssc_pkg::DIGIT_W+5)'(ssc_pkg::LUHN_MOD))
                    term[i] = term[i] - (ssc_pkg::DIGIT_W+5)'(ssc_pkg::LUHN_SUB);
            end
        end
        // balanced adder tree
        for (int i = 0; i < ssc_pkg::CARD_DIGITS/2; i++)
            lvl1[i] = term[2*i] + term[2*i+1];
        for (int i = 0; i < ssc_pkg::CARD_DIGITS/4; i++)
            lvl2[i] = lvl1[2*i] + lvl1[2*i+1];
        for (int i = 0; i < ssc_pkg::CARD_DIGITS/8; i++)
            lvl3[i] = lvl2[2*i] + lvl2[2*i+1];
        sum = lvl3[0] + lvl3[1];
    end

    // good card when the digit sum is a multiple of 10
    assign card_ok = (sum % (ssc_pkg::DIGIT_W+5)'(ssc_pkg::LUHN_MOD)) == '0;

endmodule

`default_nettype wire

/* cost_stage.sv */
/*
 * stage 1, slot costs
 * multiplies each quantity nibble by its price nibble, runs the card
 * check and registers costs, money and card_ok on the input handshake
 */
`timescale 1ns/1ps
`default_nettype none

module cost_stage (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        in_valid,
    output logic                             in_ready,
    input  wire logic [ssc_pkg::CARD_W-1:0]  card_num,
    input  wire logic [ssc_pkg::MONEY_W-1:0] input_money,
    input  wire logic [ssc_pkg::SLOT_W-1:0]  snack_num,
    input  wire logic [ssc_pkg::SLOT_W-1:0]  price,
    ssc_stage_if.src                         out
);

    logic                       card_ok_c;
    logic [ssc_pkg::COST_W-1:0] cost_c [ssc_pkg::SNACKS];

    card_check u_card_check (
        .card_num (card_num),
        .card_ok  (card_ok_c)
    );

    // ========================================
    // qty * price per slot, slot 0 = top nibble
    // ========================================
    always_comb begin
        for (int i = 0; i < ssc_pkg::SNACKS; i++) begin
            cost_c[i] = ssc_pkg::COST_W'(snack_num[(ssc_pkg::SNACKS-1-i)*ssc_pkg::DIGIT_W +:
                                                   ssc_pkg::DIGIT_W])
                      * ssc_pkg::COST_W'(price[(ssc_pkg::SNACKS-1-i)*ssc_pkg::DIGIT_W +:
                                               ssc_pkg::DIGIT_W]);
        end
    end

    // register empty or draining downstream
    assign in_ready = !out.valid || out.ready;

    always_ff @(posedge clk) begin
        if (reset)
            out.valid <= 1'b0;
        else if (in_ready)
            out.valid <= in_valid;
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out.cost    <= cost_c;
            out.money   <= input_money;
            out.card_ok <= card_ok_c;
        end
    end

    // a held transaction is not dropped while stalled
    a_hold_until_xfer: assert property (
        @(posedge clk) disable iff (reset)
        out.valid && !out.ready |=> out.valid
    );

endmodule

`default_nettype wire

/* sort_stage.sv */
/*
 * stage 2, descending merge sort
 * bottom-up merge of the eight costs: sorted pairs, two sorted fours,
 * then one sorted eight; money and card_ok ride along in the register
 */
`timescale 1ns/1ps
`default_nettype none

module sort_stage (
    input  wire logic clk,
    input  wire logic reset,
    ssc_stage_if.dst  in,
    ssc_stage_if.src  out
);

    logic [ssc_pkg::COST_W-1:0] run1 [ssc_pkg::SNACKS];   // sorted pairs
    logic [ssc_pkg::COST_W-1:0] run2 [ssc_pkg::SNACKS];   // sorted fours
    logic [ssc_pkg::COST_W-1:0] run4 [ssc_pkg::SNACKS];   // fully sorted

    // ========================================
    // merge adjacent sorted runs of length run
    // ========================================
    // ties take the left item first
    function automatic void merge_runs(
        input  logic [ssc_pkg::COST_W-1:0] v [ssc_pkg::SNACKS],
        input  int                         run,
        output logic [ssc_pkg::COST_W-1:0] o [ssc_pkg::SNACKS]
    );
        int   base;
        int   li;
        int   ri;
        logic take_l;
        for (base = 0; base < ssc_pkg::SNACKS; base = base + 2*run) begin
            li = base;                  // left run head
            ri = base + run;            // right run head
            for (int k = base; k < base + 2*run; k++) begin
                // right exhausted, or left head is the larger one
                take_l = (ri >= base + 2*run) || (li < base + run && v[li] >= v[ri]);
                if (take_l) begin
                    o[k] = v[li];
                    li   = li + 1;
                end else begin
                    o[k] = v[ri];
                    ri   = ri + 1;
                end
            end
        end
    endfunction

    always_comb begin
        merge_runs(in.cost, 1, run1);   // pairs
        merge_runs(run1,    2, run2);   // 4-way merges
        merge_runs(run2,    4, run4);   // 8-way merge
    end

    // ========================================
    // output register and handshake
    // ========================================
    assign in.ready = !out.valid || out.ready;

    always_ff @(posedge clk) begin
        if (reset)
            out.valid <= 1'b0;
        else if (in.ready)
            out.valid <= in.valid;
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            out.cost    <= run4;
            out.money   <= in.money;
            out.card_ok <= in.card_ok;
        end
    end

    // each neighbour pair of the registered result is in order
    for (genvar g = 0; g < ssc_pkg::SNACKS - 1; g++) begin : g_order_chk
        a_desc: assert property (
            @(posedge clk) disable iff (reset)
            out.valid |-> out.cost[g] >= out.cost[g+1]
        );
    end

endmodule

`default_nettype wire

/* change_stage.sv */
/*
 * stage 3, greedy purchase
 * walks the sorted costs from the largest, subtracting while each fits;
 * the first cost that does not fit stops the walk for good.
 * holds card_ok and the change until the output handshake
 */
`timescale 1ns/1ps
`default_nettype none

module change_stage (
    input  wire logic                   clk,
    input  wire logic                   reset,
    ssc_stage_if.dst                    in,
    output logic                        out_valid,
    input  wire logic                   out_ready,
    output logic                        card_ok,
    output logic [ssc_pkg::MONEY_W-1:0] out_change
);

    logic [ssc_pkg::MONEY_W-1:0] rem;         // remainder down the chain
    logic                        stop;        // sticky once a cost overflows
    logic [ssc_pkg::MONEY_W-1:0] change_c;

    // ========================================
    // subtraction chain with stop flag
    // ========================================
    always_comb begin
        logic [ssc_pkg::MONEY_W-1:0] c;
        rem  = in.money;
        stop = 1'b0;
        for (int i = 0; i < ssc_pkg::SNACKS; i++) begin
            c = ssc_pkg::MONEY_W'(in.cost[i]);
            if (!stop && c <= rem)
                rem = rem - c;                // bought
            else
                stop = 1'b1;                  // cheaper ones after are skipped
        end
        // bad card buys nothing
        change_c = in.card_ok ? rem : in.money;
    end

    assign in.ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset)
            out_valid <= 1'b0;
        else if (in.ready)
            out_valid <= in.valid;
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            out_change <= change_c;
            card_ok    <= in.card_ok;
        end
    end

    // outputs frozen while the consumer stalls
    a_stall_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> $stable(out_valid) && $stable(out_change)
                                    && $stable(card_ok)
    );

    // change never exceeds what was paid
    a_change_le_money: assert property (
        @(posedge clk) disable iff (reset)
        in.valid && in.ready |=> out_change <= $past(in.money)
    );

endmodule

`default_nettype wire

/* ssc.sv */
/*
 * snack shopping calculator, top level
 * three stage pipeline: cost and card check, descending sort, greedy
 * change; valid/ready handshake on both ends
 */
`timescale 1ns/1ps
`default_nettype none

module ssc (
    input  wire logic                        clk,
    input  wire logic                        reset,
    // request side
    input  wire logic                        in_valid,
    output logic                             in_ready,
    input  wire logic [ssc_pkg::CARD_W-1:0]  card_num,
    input  wire logic [ssc_pkg::MONEY_W-1:0] input_money,
    input  wire logic [ssc_pkg::SLOT_W-1:0]  snack_num,
    input  wire logic [ssc_pkg::SLOT_W-1:0]  price,
    // result side
    output logic                             out_valid,
    input  wire logic                        out_ready,
    output logic                             card_ok,
    output logic [ssc_pkg::MONEY_W-1:0]      out_change
);

    ssc_stage_if s1_if ();    // cost -> sort
    ssc_stage_if s2_if ();    // sort -> change, costs descending

    cost_stage u_cost_stage (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .card_num    (card_num),
        .input_money (input_money),
        .snack_num   (snack_num),
        .price       (price),
        .out         (s1_if)
    );

    sort_stage u_sort_stage (
        .clk   (clk),
        .reset (reset),
        .in    (s1_if),
        .out   (s2_if)
    );

    change_stage u_change_stage (
        .clk        (clk),
        .reset      (reset),
        .in         (s2_if),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .card_ok    (card_ok),
        .out_change (out_change)
    );

endmodule

`default_nettype wire

/* tb_ssc.sv */
/*
 * testbench for the snack shopping calculator
 * lcg driven valid/ready traffic with a few directed corner cases,
 * a reference model of card check, sort and greedy change,
 * and an in-order scoreboard
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ssc;

    localparam int N_TXN   = 300;
    localparam int N_DIR   = 4;                  // directed cases go first
    localparam int TIMEOUT = N_TXN * 20 + 100;   // cycles, worst case stalls

    logic                        clk;
    logic                        reset;
    logic                        in_valid;
    logic                        in_ready;
    logic [ssc_pkg::CARD_W-1:0]  card_num;
    logic [ssc_pkg::MONEY_W-1:0] input_money;
    logic [ssc_pkg::SLOT_W-1:0]  snack_num;
    logic [ssc_pkg::SLOT_W-1:0]  price;
    logic                        out_valid;
    logic                        out_ready;
    logic                        card_ok;
    logic [ssc_pkg::MONEY_W-1:0] out_change;

    logic [31:0]                 lcg_state = 32'hf089;
    logic [ssc_pkg::MONEY_W:0]   exp_q [$];      // {card_ok, change}, oldest first
    logic [ssc_pkg::MONEY_W:0]   held_val;       // outputs seen on a stalled edge
    logic                        held;
    logic                        took;           // input accepted on last edge
    int                          sent;
    int                          cycles;

    ssc dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // ========================================
    // reference model
    // ========================================
    // luhn sum of the first n digits, msd first, even positions doubled
    function automatic int digit_sum(input logic [ssc_pkg::CARD_W-1:0] card, input int n);
        int d;
        int s;
        s = 0;
        for (int i = 0; i < n; i++) begin
            d = int'(card[(ssc_pkg::CARD_DIGITS-1-i)*ssc_pkg::DIGIT_W +: ssc_pkg::DIGIT_W]);
            if (i % 2 == 0)
                d = 2 * d;
            if (d >= 10)
                d = d - 9;
            s += d;
        end
        return s;
    endfunction

    // last digit is never doubled, so it can close the sum to a multiple of 10
    function automatic logic [ssc_pkg::CARD_W-1:0] fix_luhn(
        input logic [ssc_pkg::CARD_W-1:0] card
    );
        int s;
        s = digit_sum(card, ssc_pkg::CARD_DIGITS - 1);
        card[3:0] = 4'((10 - s % 10) % 10);
        return card;
    endfunction

    function automatic logic [ssc_pkg::MONEY_W:0] model_result();
        int   c [ssc_pkg::SNACKS];
        int   t;
        int   rem;
        logic ok;
        ok = (digit_sum(card_num, ssc_pkg::CARD_DIGITS) % 10) == 0;
        for (int i = 0; i < ssc_pkg::SNACKS; i++)
            c[i] = int'(snack_num[i*4 +: 4]) * int'(price[i*4 +: 4]);   // slot order irrelevant
        for (int i = 0; i < ssc_pkg::SNACKS; i++) begin     // selection sort, largest first
            for (int j = i + 1; j < ssc_pkg::SNACKS; j++) begin
                if (c[j] > c[i]) begin
                    t    = c[i];
                    c[i] = c[j];
                    c[j] = t;
                end
            end
        end
        rem = int'(input_money);
        for (int i = 0; i < ssc_pkg::SNACKS; i++) begin
            if (c[i] > rem)
                break;              // first one that does not fit ends buying
            rem -= c[i];
        end
        if (!ok)
            rem = int'(input_money);    // bad card, nothing bought
        return {ok, ssc_pkg::MONEY_W'(rem)};
    endfunction

    // ========================================
    // stimulus
    // ========================================
    task automatic load_txn(input int idx);
        logic [ssc_pkg::CARD_W-1:0] card;
        int                         mode;
        for (int i = 0; i < ssc_pkg::CARD_DIGITS; i++)
            card[i*4 +: 4] = 4'((next_rand() >> 16) % 10);     // bcd digits only
        mode        = int'((next_rand() >> 16) % 4);
        snack_num   = next_rand();
        price       = next_rand();
        input_money = ssc_pkg::MONEY_W'(next_rand() >> 12);
        if (mode == 0)
            snack_num &= 32'h3333_3333;     // small quantities, often all bought
        if (mode == 1)
            snack_num &= 32'hf0f0_f0f0;     // zero cost slots
        card_num = (((next_rand() >> 20) & 32'd1) != 0) ? fix_luhn(card) : card;
        case (idx)
            0: begin                        // one below the largest cost
                snack_num   = 32'hf111_1111;
                price       = 32'hf111_1111;
                input_money = 9'd224;
                card_num    = fix_luhn(card);
            end
            1: begin                        // nothing ordered
                snack_num   = 32'h0;
                input_money = 9'd100;
                card_num    = fix_luhn(card);
            end
            2: begin
                input_money = 9'd300;
                card_num    = fix_luhn(card) ^ 64'h1;   // last digit off by one
            end
            3: begin                        // costs 1..8, all bought
                snack_num   = 32'h1111_1111;
                price       = 32'h1234_5678;
                input_money = 9'd40;
                card_num    = fix_luhn(card);
            end
            default: ;
        endcase
    endtask

    // one cycle: drive on the falling edge, sample handshakes on the rising edge
    task automatic step();
        logic [ssc_pkg::MONEY_W:0] exp;
        @(negedge clk);
        out_ready = ((next_rand() >> 16) % 4) != 0;
        if (!in_valid || took) begin    // payload held while not accepted
            in_valid = 1'b0;
            if (sent < N_TXN && (sent < N_DIR || ((next_rand() >> 16) % 4) != 0)) begin
                load_txn(sent);
                in_valid = 1'b1;
            end
        end
        @(posedge clk);
        took = in_valid && in_ready;
        if (took) begin
            exp_q.push_back(model_result());
            sent++;
        end
        if (held) begin
            assert (out_valid) else stop_on_error("out_valid dropped while stalled");
            assert ({card_ok, out_change} === held_val)
                else stop_on_error($sformatf(
                    "FAIL card_ok/out_change stalled got %h/%h held %h/%h",
                    card_ok, out_change, held_val[ssc_pkg::MONEY_W],
                    held_val[ssc_pkg::MONEY_W-1:0]));
        end
        if (out_valid && out_ready) begin
            assert (exp_q.size() > 0) else stop_on_error("output transfer with nothing pending");
            exp = exp_q.pop_front();
            assert (card_ok === exp[ssc_pkg::MONEY_W])
                else stop_on_error($sformatf("FAIL card_ok got %h expected %h",
                    card_ok, exp[ssc_pkg::MONEY_W]));
            assert (out_change === exp[ssc_pkg::MONEY_W-1:0])
                else stop_on_error($sformatf("FAIL out_change got %h expected %h",
                    out_change, exp[ssc_pkg::MONEY_W-1:0]));
        end
        held     = out_valid && !out_ready;
        held_val = {card_ok, out_change};
    endtask

    initial begin
        reset       = 1'b1;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        card_num    = '0;
        input_money = '0;
        snack_num   = '0;
        price       = '0;
        took        = 1'b0;
        held        = 1'b0;
        held_val    = '0;
        sent        = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        assert (out_valid === 1'b0 && in_ready === 1'b1)
            else stop_on_error("pipeline not empty and ready after reset");
        while (sent < N_TXN || exp_q.size() != 0)
            step();
        repeat (2 * ssc_pkg::STAGES) step();    // no stray outputs after the last one
        $display("Simulation passed");
        $finish;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        stop_on_error($sformatf("timeout, run did not finish in %0d cycles", TIMEOUT));
    end

endmodule

`default_nettype wire

/* compile.f */
ssc_pkg.sv
ssc_stage_if.sv
card_check.sv
cost_stage.sv
sort_stage.sv
change_stage.sv
ssc.sv
tb_ssc.sv

/* run.sh */
#!/bin/sh
# build and run the snack shopping calculator testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_ssc -o tb_ssc

# the grep decides pass or fail
out=$(./obj_dir/tb_ssc) || true
echo "$out"
echo "$out" | grep -q "Simulation passed"
